/* src/swc_types_pkg.sv */
package swc_types_pkg;

	// ======================================================================
	// data path widths
	// ======================================================================

	typedef logic [31:0] cell_word_t;

	// buffer index for at most 64 buffers
	typedef logic [5:0]  buf_ptr_t;

	// one bit per output port
	typedef logic [3:0]  port_mask_t;

	// cells per packet from 1 to 8
	typedef logic [3:0]  cell_cnt_t;

	// remaining readers of a buffer from 0 to 4
	typedef logic [2:0]  ref_cnt_t;

	// word slot inside a cell
	typedef logic [1:0]  beat_idx_t;

	// ======================================================================
	// records
	// ======================================================================

	typedef struct packed {
		port_mask_t mask;
		cell_cnt_t  cells;
	} pkt_desc_t;

	// first and last mark the packet edges rather than the cell edges
	typedef struct packed {
		buf_ptr_t ptr;
		logic     first;
		logic     last;
	} q_entry_t;

	typedef struct packed {
		cell_word_t data;
		port_mask_t sel;
		logic       first;
		logic       last;
	} out_beat_t;

endpackage

/* src/swc_ctrl_pkg.sv */
package swc_ctrl_pkg;

	// fixed geometry of the switch
	localparam int CELL_WORDS = 4;
	localparam int NUM_PORTS  = 4;

	typedef enum logic [1:0] {
		ENQ_IDLE,
		ENQ_ADMIT,
		ENQ_WRITE,
		ENQ_NEXT
	} enq_state_e;

	// release doubles as an arbitration slot
	typedef enum logic [1:0] {
		DEQ_IDLE,
		DEQ_GRANT,
		DEQ_READ,
		DEQ_RELEASE
	} deq_state_e;

endpackage

/* src/swc_free_queue.sv */
module swc_free_queue import swc_types_pkg::*; #(
	parameter int NUM_BUFS = 32
) (
	input  logic                      clk,
	input  logic                      rstn,
	input  logic                      i_alloc,
	output buf_ptr_t                  o_ptr,
	input  logic                      i_release,
	input  buf_ptr_t                  i_rel_ptr,
	output logic [$clog2(NUM_BUFS):0] o_count,
	output logic                      o_init_done
);

	localparam int AW = $clog2(NUM_BUFS);

	buf_ptr_t      mem [NUM_BUFS];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;
	logic [AW-1:0] init_cnt;
	logic          init_done;
	logic          push;
	buf_ptr_t      push_ptr;
	logic          pop;

	// init counter owns the write side until every pointer is loaded
	assign push     = init_done ? i_release : 1'b1;
	assign push_ptr = init_done ? i_rel_ptr : buf_ptr_t'(init_cnt);
	assign pop      = init_done & i_alloc;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			init_cnt  <= '0;
			init_done <= 1'b0;
		end else if (!init_done) begin
			init_cnt <= init_cnt + 1'b1;
			if (init_cnt == AW'(NUM_BUFS - 1))
				init_done <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= push_ptr;
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// head is visible before the pop
	assign o_ptr       = mem[rd_ptr];
	assign o_count     = count;
	assign o_init_done = init_done;

endmodule

/* src/swc_port_queue.sv */
module swc_port_queue import swc_types_pkg::*; #(
	parameter int PQ_DEPTH = 16
) (
	input  logic                      clk,
	input  logic                      rstn,
	input  logic                      i_push,
	input  q_entry_t                  i_entry,
	input  logic                      i_pop,
	output q_entry_t                  o_head,
	output logic                      o_not_empty,
	output logic [$clog2(PQ_DEPTH):0] o_free_slots
);

	localparam int AW = $clog2(PQ_DEPTH);

	q_entry_t      mem [PQ_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;

	always_ff @(posedge clk) begin
		if (i_push)
			mem[wr_ptr] <= i_entry;
	end

	// enqueue only pushes into room it has reserved
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (i_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (i_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({i_push, i_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign o_head       = mem[rd_ptr];
	assign o_not_empty  = (count != '0);
	assign o_free_slots = (AW + 1)'(PQ_DEPTH) - count;

endmodule

/* src/swc_buffer_ram.sv */
module swc_buffer_ram import swc_types_pkg::*, swc_ctrl_pkg::*; #(
	parameter int NUM_BUFS = 32
) (
	input  logic       clk,
	input  logic       i_wr_en,
	input  buf_ptr_t   i_wr_ptr,
	input  beat_idx_t  i_wr_idx,
	input  cell_word_t i_wr_data,
	input  buf_ptr_t   i_rd_ptr,
	input  beat_idx_t  i_rd_idx,
	output cell_word_t o_rd_data,
	input  logic       i_ref_wr_en,
	input  buf_ptr_t   i_ref_wr_ptr,
	input  ref_cnt_t   i_ref_wr_val,
	input  buf_ptr_t   i_ref_rd_ptr,
	output ref_cnt_t   o_ref_rd_val
);

	localparam int AW = $clog2(NUM_BUFS);
	localparam int DW = AW + $clog2(CELL_WORDS);

	cell_word_t    data_mem [NUM_BUFS * CELL_WORDS];
	ref_cnt_t      ref_mem [NUM_BUFS];
	logic [DW-1:0] wr_addr;
	logic [DW-1:0] rd_addr;

	// word address is buffer index then word slot
	assign wr_addr = {i_wr_ptr[AW-1:0], i_wr_idx};
	assign rd_addr = {i_rd_ptr[AW-1:0], i_rd_idx};

	always_ff @(posedge clk) begin
		if (i_wr_en)
			data_mem[wr_addr] <= i_wr_data;
		o_rd_data <= data_mem[rd_addr];
	end

	// one count per buffer with a one-cycle read
	always_ff @(posedge clk) begin
		if (i_ref_wr_en)
			ref_mem[i_ref_wr_ptr[AW-1:0]] <= i_ref_wr_val;
		o_ref_rd_val <= ref_mem[i_ref_rd_ptr[AW-1:0]];
	end

endmodule

/* src/swc_enqueue.sv */
module swc_enqueue import swc_types_pkg::*, swc_ctrl_pkg::*; #(
	parameter int NUM_BUFS = 32,
	parameter int PQ_DEPTH = 16
) (
	input  logic                      clk,
	input  logic                      rstn,
	input  logic                      i_desc_valid,
	input  pkt_desc_t                 i_desc,
	output logic                      o_desc_ready,
	input  logic                      i_data_valid,
	input  cell_word_t                i_data,
	output logic                      o_data_ready,
	input  logic [$clog2(NUM_BUFS):0] i_free_count,
	input  logic                      i_fq_ready,
	output logic                      o_alloc,
	input  buf_ptr_t                  i_ptr,
	output logic                      o_wr_en,
	output buf_ptr_t                  o_wr_ptr,
	output beat_idx_t                 o_wr_idx,
	output cell_word_t                o_wr_data,
	output logic                      o_ref_wr_en,
	output ref_cnt_t                  o_ref_val,
	input  logic [$clog2(PQ_DEPTH):0] i_pq_free [NUM_PORTS],
	output port_mask_t                o_push,
	output q_entry_t                  o_entry
);

	enq_state_e state;
	pkt_desc_t  desc_q;
	buf_ptr_t   cur_ptr;
	beat_idx_t  beat;
	cell_cnt_t  cells_left;
	logic       first_q;
	logic       fits;
	logic       desc_take;
	logic       word_take;
	logic       cell_done;
	ref_cnt_t   fanout;

	// ======================================================================
	// handshakes
	// ======================================================================

	// held off until the free queue has loaded every pointer
	assign o_desc_ready = (state == ENQ_IDLE) && i_fq_ready;
	assign desc_take    = i_desc_valid && o_desc_ready;
	assign o_data_ready = (state == ENQ_WRITE);
	assign word_take    = i_data_valid && o_data_ready;
	assign cell_done    = word_take && (beat == beat_idx_t'(CELL_WORDS - 1));

	// whole packet must fit, so no stall once writing starts
	always_comb begin
		fits = (i_free_count >= desc_q.cells);
		for (int p = 0; p < NUM_PORTS; p++) begin
			if (desc_q.mask[p] && (i_pq_free[p] < desc_q.cells))
				fits = 1'b0;
		end
	end

	// one reader per destination port
	always_comb begin
		fanout = '0;
		for (int p = 0; p < NUM_PORTS; p++)
			fanout = fanout + ref_cnt_t'(desc_q.mask[p]);
	end

	// ======================================================================
	// cell sequencing
	// ======================================================================

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state      <= ENQ_IDLE;
			beat       <= '0;
			cells_left <= '0;
			first_q    <= 1'b0;
		end else begin
			case (state)
				ENQ_IDLE: begin
					if (desc_take)
						state <= ENQ_ADMIT;
				end
				ENQ_ADMIT: begin
					if (fits) begin
						cells_left <= desc_q.cells;
						first_q    <= 1'b1;
						beat       <= '0;
						state      <= ENQ_WRITE;
					end
				end
				ENQ_WRITE: begin
					if (word_take)
						beat <= beat + 1'b1;
					if (cell_done) begin
						cells_left <= cells_left - 1'b1;
						state      <= ENQ_NEXT;
					end
				end
				ENQ_NEXT: begin
					first_q <= 1'b0;
					state   <= (cells_left == '0) ? ENQ_IDLE : ENQ_WRITE;
				end
				default: state <= ENQ_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (desc_take)
			desc_q <= i_desc;
		if (o_alloc)
			cur_ptr <= i_ptr;
	end

	// pointer taken on entry to every cell
	assign o_alloc = ((state == ENQ_ADMIT) && fits) ||
	                 ((state == ENQ_NEXT) && (cells_left != '0));

	assign o_wr_en     = word_take;
	assign o_wr_ptr    = cur_ptr;
	assign o_wr_idx    = beat;
	assign o_wr_data   = i_data;
	assign o_ref_wr_en = cell_done;
	assign o_ref_val   = fanout;
	assign o_push      = cell_done ? desc_q.mask : '0;

	always_comb begin
		o_entry       = '0;
		o_entry.ptr   = cur_ptr;
		o_entry.first = first_q;
		o_entry.last  = (cells_left == cell_cnt_t'(1));
	end

endmodule

/* src/swc_dequeue.sv */
module swc_dequeue import swc_types_pkg::*, swc_ctrl_pkg::*; (
	input  logic       clk,
	input  logic       rstn,
	input  port_mask_t i_not_empty,
	input  q_entry_t   i_heads [NUM_PORTS],
	output port_mask_t o_pop,
	input  port_mask_t i_out_ready,
	output buf_ptr_t   o_rd_ptr,
	output beat_idx_t  o_rd_idx,
	input  cell_word_t i_rd_data,
	output buf_ptr_t   o_ref_rd_ptr,
	input  ref_cnt_t   i_ref_val,
	output logic       o_ref_wr_en,
	output ref_cnt_t   o_ref_val,
	output logic       o_release,
	output buf_ptr_t   o_rel_ptr,
	output logic       o_out_valid,
	output out_beat_t  o_out
);

	localparam int PW = $clog2(NUM_PORTS);

	deq_state_e    state;
	port_mask_t    cand;
	logic          found;
	logic [PW-1:0] pick;
	logic [PW-1:0] probe;
	logic [PW-1:0] last_grant;
	q_entry_t      cur;
	port_mask_t    sel_q;
	beat_idx_t     beat;
	logic          out_valid_q;
	logic          out_head_q;

	// ready only counts at cell start
	assign cand = i_not_empty & i_out_ready;

	// ======================================================================
	// round robin starting after the last grant
	// ======================================================================

	always_comb begin
		found = 1'b0;
		pick  = last_grant;
		probe = last_grant;
		for (int k = 1; k <= NUM_PORTS; k++) begin
			probe = PW'((int'(last_grant) + k) % NUM_PORTS);
			if (!found && cand[probe]) begin
				found = 1'b1;
				pick  = probe;
			end
		end
	end

	assign o_pop = ((state == DEQ_GRANT) && found) ? port_mask_t'(1 << pick) : '0;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state       <= DEQ_IDLE;
			last_grant  <= '0;
			beat        <= '0;
			out_valid_q <= 1'b0;
			out_head_q  <= 1'b0;
		end else begin
			// valid trails the read address by the RAM latency
			out_valid_q <= (state == DEQ_READ);
			out_head_q  <= (state == DEQ_READ) && (beat == '0);
			case (state)
				DEQ_IDLE, DEQ_RELEASE: begin
					state <= (|cand) ? DEQ_GRANT : DEQ_IDLE;
				end
				DEQ_GRANT: begin
					if (found) begin
						last_grant <= pick;
						beat       <= '0;
						state      <= DEQ_READ;
					end else begin
						// ready dropped since idle
						state <= DEQ_IDLE;
					end
				end
				DEQ_READ: begin
					beat <= beat + 1'b1;
					if (beat == beat_idx_t'(CELL_WORDS - 1))
						state <= DEQ_RELEASE;
				end
				default: state <= DEQ_IDLE;
			endcase
		end
	end

	// held until the next grant, which covers the trailing beat
	always_ff @(posedge clk) begin
		if ((state == DEQ_GRANT) && found) begin
			cur   <= i_heads[pick];
			sel_q <= o_pop;
		end
	end

	// ======================================================================
	// read-out and buffer release
	// ======================================================================

	assign o_rd_ptr     = cur.ptr;
	assign o_rd_idx     = beat;
	assign o_ref_rd_ptr = cur.ptr;

	// count has been readable since the cycle after grant
	assign o_ref_wr_en = (state == DEQ_RELEASE);
	assign o_ref_val   = i_ref_val - 1'b1;
	assign o_release   = (state == DEQ_RELEASE) && (i_ref_val == ref_cnt_t'(1));
	assign o_rel_ptr   = cur.ptr;

	assign o_out_valid = out_valid_q;

	always_comb begin
		o_out       = '0;
		o_out.data  = i_rd_data;
		o_out.sel   = sel_q;
		o_out.first = cur.first & out_head_q;
		o_out.last  = cur.last;
	end

endmodule

/* src/switch_core.sv */
module switch_core import swc_types_pkg::*, swc_ctrl_pkg::*; #(
	parameter int NUM_BUFS = 32,
	parameter int PQ_DEPTH = 16
) (
	input  logic       clk,
	input  logic       rstn,
	input  logic       i_desc_valid,
	input  pkt_desc_t  i_desc,
	output logic       o_desc_ready,
	input  logic       i_data_valid,
	input  cell_word_t i_data,
	output logic       o_data_ready,
	output logic       o_out_valid,
	output out_beat_t  o_out,
	input  port_mask_t i_out_ready
);

	logic [$clog2(NUM_BUFS):0] fq_count;
	logic                      fq_init_done;
	logic                      fq_alloc;
	buf_ptr_t                  fq_ptr;
	logic                      fq_release;
	buf_ptr_t                  fq_rel_ptr;

	logic       wr_en;
	buf_ptr_t   wr_ptr;
	beat_idx_t  wr_idx;
	cell_word_t wr_data;
	buf_ptr_t   rd_ptr;
	beat_idx_t  rd_idx;
	cell_word_t rd_data;

	logic     enq_ref_wr_en;
	ref_cnt_t enq_ref_val;
	logic     deq_ref_wr_en;
	ref_cnt_t deq_ref_val;
	buf_ptr_t ref_rd_ptr;
	ref_cnt_t ref_rd_val;
	logic     ref_wr_en;
	buf_ptr_t ref_wr_ptr;
	ref_cnt_t ref_wr_val;
	logic     ref_pend;
	buf_ptr_t ref_pend_ptr;
	ref_cnt_t ref_pend_val;

	logic [$clog2(PQ_DEPTH):0] pq_free [NUM_PORTS];
	q_entry_t                  pq_head [NUM_PORTS];
	port_mask_t                pq_not_empty;
	port_mask_t                pq_push;
	port_mask_t                pq_pop;
	q_entry_t                  pq_entry;

	swc_enqueue #(
		.NUM_BUFS (NUM_BUFS),
		.PQ_DEPTH (PQ_DEPTH)
	) u_enqueue (
		.clk          (clk),
		.rstn         (rstn),
		.i_desc_valid (i_desc_valid),
		.i_desc       (i_desc),
		.o_desc_ready (o_desc_ready),
		.i_data_valid (i_data_valid),
		.i_data       (i_data),
		.o_data_ready (o_data_ready),
		.i_free_count (fq_count),
		.i_fq_ready   (fq_init_done),
		.o_alloc      (fq_alloc),
		.i_ptr        (fq_ptr),
		.o_wr_en      (wr_en),
		.o_wr_ptr     (wr_ptr),
		.o_wr_idx     (wr_idx),
		.o_wr_data    (wr_data),
		.o_ref_wr_en  (enq_ref_wr_en),
		.o_ref_val    (enq_ref_val),
		.i_pq_free    (pq_free),
		.o_push       (pq_push),
		.o_entry      (pq_entry)
	);

	swc_free_queue #(
		.NUM_BUFS (NUM_BUFS)
	) u_free_queue (
		.clk         (clk),
		.rstn        (rstn),
		.i_alloc     (fq_alloc),
		.o_ptr       (fq_ptr),
		.i_release   (fq_release),
		.i_rel_ptr   (fq_rel_ptr),
		.o_count     (fq_count),
		.o_init_done (fq_init_done)
	);

	// ======================================================================
	// reference count write merge
	// ======================================================================

	// dequeue write-back goes first and a colliding enqueue write slips a cycle
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn)
			ref_pend <= 1'b0;
		else
			ref_pend <= enq_ref_wr_en && deq_ref_wr_en;
	end

	always_ff @(posedge clk) begin
		if (enq_ref_wr_en) begin
			ref_pend_ptr <= wr_ptr;
			ref_pend_val <= enq_ref_val;
		end
	end

	always_comb begin
		if (deq_ref_wr_en) begin
			ref_wr_en  = 1'b1;
			ref_wr_ptr = ref_rd_ptr;
			ref_wr_val = deq_ref_val;
		end else if (ref_pend) begin
			ref_wr_en  = 1'b1;
			ref_wr_ptr = ref_pend_ptr;
			ref_wr_val = ref_pend_val;
		end else begin
			ref_wr_en  = enq_ref_wr_en;
			ref_wr_ptr = wr_ptr;
			ref_wr_val = enq_ref_val;
		end
	end

	swc_buffer_ram #(
		.NUM_BUFS (NUM_BUFS)
	) u_buffer_ram (
		.clk          (clk),
		.i_wr_en      (wr_en),
		.i_wr_ptr     (wr_ptr),
		.i_wr_idx     (wr_idx),
		.i_wr_data    (wr_data),
		.i_rd_ptr     (rd_ptr),
		.i_rd_idx     (rd_idx),
		.o_rd_data    (rd_data),
		.i_ref_wr_en  (ref_wr_en),
		.i_ref_wr_ptr (ref_wr_ptr),
		.i_ref_wr_val (ref_wr_val),
		.i_ref_rd_ptr (ref_rd_ptr),
		.o_ref_rd_val (ref_rd_val)
	);

	for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port_q
		swc_port_queue #(
			.PQ_DEPTH (PQ_DEPTH)
		) u_port_queue (
			.clk          (clk),
			.rstn         (rstn),
			.i_push       (pq_push[p]),
			.i_entry      (pq_entry),
			.i_pop        (pq_pop[p]),
			.o_head       (pq_head[p]),
			.o_not_empty  (pq_not_empty[p]),
			.o_free_slots (pq_free[p])
		);
	end

	swc_dequeue u_dequeue (
		.clk          (clk),
		.rstn         (rstn),
		.i_not_empty  (pq_not_empty),
		.i_heads      (pq_head),
		.o_pop        (pq_pop),
		.i_out_ready  (i_out_ready),
		.o_rd_ptr     (rd_ptr),
		.o_rd_idx     (rd_idx),
		.i_rd_data    (rd_data),
		.o_ref_rd_ptr (ref_rd_ptr),
		.i_ref_val    (ref_rd_val),
		.o_ref_wr_en  (deq_ref_wr_en),
		.o_ref_val    (deq_ref_val),
		.o_release    (fq_release),
		.o_rel_ptr    (fq_rel_ptr),
		.o_out_valid  (o_out_valid),
		.o_out        (o_out)
	);

endmodule

/* verification/switch_core_checker.sv */
module switch_core_checker import swc_types_pkg::*; #(
	parameter int NUM_BUFS = 32
) (
	input logic                      clk,
	input logic                      rstn,
	input logic                      i_desc_valid,
	input pkt_desc_t                 i_desc,
	input logic                      o_desc_ready,
	input logic                      o_out_valid,
	input out_beat_t                 o_out,
	input logic                      fq_alloc,
	input logic [$clog2(NUM_BUFS):0] fq_count
);

	timeunit 1ns;
	timeprecision 100ps;

	// source holds the descriptor until it is taken
	assert property (@(posedge clk) disable iff (!rstn)
		(i_desc_valid && !o_desc_ready) |=> (i_desc_valid && $stable(i_desc)))
		else $error("descriptor changed or dropped before it was accepted");

	assert property (@(posedge clk) disable iff (!rstn)
		o_out_valid |-> $onehot(o_out.sel))
		else $error("output port select is not one-hot");

	// one cell is exactly four beats
	assert property (@(posedge clk) disable iff (!rstn)
		$rose(o_out_valid) |-> o_out_valid [*4] ##1 !o_out_valid)
		else $error("output valid did not run for exactly four cycles");

	assert property (@(posedge clk) disable iff (!rstn)
		fq_alloc |-> (fq_count != '0))
		else $error("pointer allocated from an empty free queue");

endmodule

bind switch_core switch_core_checker #(
	.NUM_BUFS (NUM_BUFS)
) u_checker (
	.clk          (clk),
	.rstn         (rstn),
	.i_desc_valid (i_desc_valid),
	.i_desc       (i_desc),
	.o_desc_ready (o_desc_ready),
	.o_out_valid  (o_out_valid),
	.o_out        (o_out),
	.fq_alloc     (fq_alloc),
	.fq_count     (fq_count)
);

/* verification/switch_core_tb.sv */
module switch_core_tb import swc_types_pkg::*, swc_ctrl_pkg::*;;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_BUFS   = 32;
	localparam int NUM_PKTS   = 300;
	localparam int WAIT_LIMIT = 2000;
	localparam int EXP_DEPTH  = 256;

	typedef struct packed {
		cell_word_t data;
		logic       first;
		logic       last;
	} exp_beat_t;

	logic       clk;
	logic       rstn;
	logic       i_desc_valid;
	pkt_desc_t  i_desc;
	logic       o_desc_ready;
	logic       i_data_valid;
	cell_word_t i_data;
	logic       o_data_ready;
	logic       o_out_valid;
	out_beat_t  o_out;
	port_mask_t i_out_ready;

	// expected beats per port in rings indexed by running counters
	exp_beat_t  exp_mem [NUM_PORTS][EXP_DEPTH];
	int         exp_head [NUM_PORTS];
	int         exp_tail [NUM_PORTS];
	logic       drain_all;
	port_mask_t rdy_prev;
	port_mask_t cell_sel;
	int         beat_in_cell;
	int         out_port;
	exp_beat_t  exp_b;

	switch_core u_dut (
		.clk          (clk),
		.rstn         (rstn),
		.i_desc_valid (i_desc_valid),
		.i_desc       (i_desc),
		.o_desc_ready (o_desc_ready),
		.i_data_valid (i_data_valid),
		.i_data       (i_data),
		.o_data_ready (o_data_ready),
		.o_out_valid  (o_out_valid),
		.o_out        (o_out),
		.i_out_ready  (i_out_ready)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic report_fail(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	function automatic int sel_to_port(input port_mask_t sel);
		int idx;
		idx = 0;
		for (int p = 0; p < NUM_PORTS; p++) begin
			if (sel[p])
				idx = p;
		end
		return idx;
	endfunction

	function automatic logic model_empty();
		logic empty;
		empty = 1'b1;
		for (int p = 0; p < NUM_PORTS; p++) begin
			if (exp_head[p] != exp_tail[p])
				empty = 1'b0;
		end
		return empty;
	endfunction

	// a word goes to every port named in the mask
	task automatic expect_beat(input port_mask_t mask, input exp_beat_t b);
		for (int p = 0; p < NUM_PORTS; p++) begin
			if (mask[p]) begin
				assert (exp_tail[p] - exp_head[p] < EXP_DEPTH)
					else report_fail("expected beat store overflowed");
				exp_mem[p][exp_tail[p] % EXP_DEPTH] = b;
				exp_tail[p]++;
			end
		end
	endtask

	// entered and left just after a falling edge
	task automatic send_packet(input int pkt_no);
		pkt_desc_t d;
		exp_beat_t b;
		int        wait_cnt;
		int        gap;
		d.mask  = port_mask_t'($urandom % 15 + 1);
		d.cells = cell_cnt_t'($urandom % 8 + 1);
		i_desc       = d;
		i_desc_valid = 1'b1;
		wait_cnt     = 0;
		while (o_desc_ready !== 1'b1) begin
			@(negedge clk);
			wait_cnt++;
			assert (wait_cnt <= WAIT_LIMIT)
				else report_fail($sformatf("timeout waiting for descriptor %0d", pkt_no));
		end
		@(negedge clk);
		i_desc_valid = 1'b0;
		for (int c = 0; c < int'(d.cells); c++) begin
			for (int w = 0; w < CELL_WORDS; w++) begin
				b.data  = $urandom;
				b.first = (c == 0) && (w == 0);
				b.last  = (c == int'(d.cells) - 1);
				expect_beat(d.mask, b);
				gap = ($urandom % 4 == 0) ? int'($urandom % 3) + 1 : 0;
				repeat (gap) @(negedge clk);
				i_data       = b.data;
				i_data_valid = 1'b1;
				wait_cnt     = 0;
				while (o_data_ready !== 1'b1) begin
					@(negedge clk);
					wait_cnt++;
					assert (wait_cnt <= WAIT_LIMIT)
						else report_fail($sformatf("timeout waiting for data of packet %0d", pkt_no));
				end
				@(negedge clk);
				i_data_valid = 1'b0;
			end
		end
	endtask

	// random per-port ready drops
	initial begin
		i_out_ready = '1;
		forever begin
			@(negedge clk);
			if (drain_all)
				i_out_ready <= '1;
			else if ($urandom % 8 == 0)
				i_out_ready <= port_mask_t'($urandom | $urandom);
		end
	end

	// =====================================================================
	// output monitor
	// =====================================================================

	initial begin
		rdy_prev     = '1;
		cell_sel     = '0;
		beat_in_cell = 0;
		forever begin
			@(negedge clk);
			if (o_out_valid === 1'b1) begin
				assert ($onehot(o_out.sel))
					else report_fail($sformatf("Error: o_out.sel is %h, not one-hot", o_out.sel));
				out_port = sel_to_port(o_out.sel);
				if (beat_in_cell == 0) begin
					// grant was two cycles back
					assert (rdy_prev[out_port])
						else report_fail($sformatf("cell started on port %0d while not ready",
							out_port));
					cell_sel = o_out.sel;
				end else begin
					assert (o_out.sel == cell_sel)
						else report_fail($sformatf("Error: o_out.sel is %h, expected %h",
							o_out.sel, cell_sel));
				end
				assert (exp_head[out_port] != exp_tail[out_port])
					else report_fail($sformatf("unexpected beat on port %0d", out_port));
				exp_b = exp_mem[out_port][exp_head[out_port] % EXP_DEPTH];
				assert (o_out.data == exp_b.data)
					else report_fail($sformatf("Error: o_out.data on port %0d is %h, expected %h",
						out_port, o_out.data, exp_b.data));
				assert (o_out.first == exp_b.first)
					else report_fail($sformatf("Error: o_out.first on port %0d is %h, expected %h",
						out_port, o_out.first, exp_b.first));
				assert (o_out.last == exp_b.last)
					else report_fail($sformatf("Error: o_out.last on port %0d is %h, expected %h",
						out_port, o_out.last, exp_b.last));
				exp_head[out_port]++;
				beat_in_cell = (beat_in_cell + 1) % CELL_WORDS;
			end else begin
				assert (beat_in_cell == 0)
					else report_fail("output valid dropped in the middle of a cell");
			end
			rdy_prev = i_out_ready;
		end
	end

	// =====================================================================
	// main sequence
	// =====================================================================

	initial begin
		int wait_cnt;
		void'($urandom(32'h1cf41a9f));
		rstn         = 1'b0;
		i_desc_valid = 1'b0;
		i_desc       = '0;
		i_data_valid = 1'b0;
		i_data       = '0;
		drain_all    = 1'b0;
		for (int p = 0; p < NUM_PORTS; p++) begin
			exp_head[p] = 0;
			exp_tail[p] = 0;
		end
		repeat (5) begin
			@(negedge clk);
			assert (o_out_valid === 1'b0)
				else report_fail($sformatf("Error: o_out_valid is %h during reset", o_out_valid));
			assert (o_desc_ready === 1'b0)
				else report_fail($sformatf("Error: o_desc_ready is %h during reset",
					o_desc_ready));
			assert (o_data_ready === 1'b0)
				else report_fail($sformatf("Error: o_data_ready is %h during reset",
					o_data_ready));
		end
		rstn = 1'b1;

		// free queue loads its pointers first
		wait_cnt = 0;
		while (o_desc_ready !== 1'b1) begin
			@(negedge clk);
			wait_cnt++;
			assert (wait_cnt <= 4 * NUM_BUFS)
				else report_fail("timeout waiting for the free queue to fill after reset");
			assert (o_out_valid === 1'b0)
				else report_fail($sformatf("Error: o_out_valid is %h before any packet",
					o_out_valid));
			assert (o_data_ready === 1'b0)
				else report_fail($sformatf("Error: o_data_ready is %h before any packet",
					o_data_ready));
		end
		assert (wait_cnt >= NUM_BUFS)
			else report_fail("descriptor ready rose before the free queue was full");

		for (int n = 0; n < NUM_PKTS; n++) begin
			send_packet(n);
			repeat ($urandom % 3) @(negedge clk);
		end

		@(posedge clk);
		drain_all = 1'b1;
		wait_cnt  = 0;
		while (!model_empty()) begin
			@(negedge clk);
			wait_cnt++;
			assert (wait_cnt <= WAIT_LIMIT)
				else report_fail("timeout waiting for the port queues to drain");
		end

		// every buffer back in the free queue
		wait_cnt = 0;
		while (u_dut.fq_count != NUM_BUFS) begin
			@(negedge clk);
			wait_cnt++;
			assert (wait_cnt <= 20)
				else report_fail($sformatf("Error: fq_count is %h, expected %h",
					u_dut.fq_count, NUM_BUFS));
		end

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

/* switch_core.f */
src/swc_types_pkg.sv
src/swc_ctrl_pkg.sv
src/swc_free_queue.sv
src/swc_port_queue.sv
src/swc_buffer_ram.sv
src/swc_enqueue.sv
src/swc_dequeue.sv
src/switch_core.sv
verification/switch_core_checker.sv
verification/switch_core_tb.sv
